//--- hw/sdrc_params.svh
// Bank controller widths, bank count and queue sizing
// Shared by the RTL and the testbench
`ifndef SDRC_PARAMS_SVH
`define SDRC_PARAMS_SVH

// SDRAM geometry
`define SDRC_BANKS      4
`define SDRC_BA_W       2
`define SDRC_ROW_W      13
`define SDRC_COL_W      13

// Request fields
`define SDRC_LEN_W      7   // Burst length
`define SDRC_ID_W       4   // Request tag
`define SDRC_TMR_W      4   // tRAS/tRP/tRCD in clocks

// Rank queue
`define SDRC_RANK_DEPTH 4
`define SDRC_CNT_W      3   // Holds 0..4

`endif

//--- hw/sdrc_cmd_pkg.sv
// SDRAM command encoding as sent to the transfer controller
// Bit 1 set means a data transfer (read or write)
`include "sdrc_params.svh"

package sdrc_cmd_pkg;

   localparam int CMD_W = 2;

   typedef enum logic [CMD_W-1:0] {
      CMD_PRECHARGE = 2'b00,
      CMD_ACTIVATE  = 2'b01,
      CMD_READ      = 2'b10,
      CMD_WRITE     = 2'b11
   } sdrc_cmd_e;

endpackage

//--- hw/sdrc_bank_pkg.sv
// Bank FSM states and bank, row and column address types
`include "sdrc_params.svh"

package sdrc_bank_pkg;

   typedef enum logic [2:0] {
      BS_IDLE = 3'd0,   // Waiting for a request
      BS_PRE  = 3'd1,   // Closing the wrong row
      BS_TRP  = 3'd2,   // Precharge to activate wait
      BS_ACT  = 3'd3,   // Opening the requested row
      BS_TRCD = 3'd4,   // Activate to read/write wait
      BS_XFR  = 3'd5    // Read or write pending
   } bank_state_e;

   typedef logic [`SDRC_BA_W-1:0]  bank_t;
   typedef logic [`SDRC_ROW_W-1:0] row_t;
   typedef logic [`SDRC_COL_W-1:0] col_t;

endpackage

//--- hw/sdrc_bank_fsm.sv
// Per-bank FSM for the SDRAM bank controller
// Tracks the open row, sequences PRE/ACT/RD/WR and enforces tRAS, tRP, tRCD
`timescale 1ns/1ns
`include "sdrc_params.svh"

module sdrc_bank_fsm (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       req,
   input  sdrc_bank_pkg::row_t        raddr,
   input  sdrc_bank_pkg::col_t        caddr,
   input  logic [`SDRC_LEN_W-1:0]     len,
   input  logic [`SDRC_ID_W-1:0]      id,
   input  logic                       write,
   input  logic                       xfr_ok,     // Bank is at queue head
   input  logic                       x2b_ack,    // Only for this bank
   input  logic [`SDRC_TMR_W-1:0]     tras_delay,
   input  logic [`SDRC_TMR_W-1:0]     trp_delay,
   input  logic [`SDRC_TMR_W-1:0]     trcd_delay,
   output logic                       ack,
   output logic                       bank_req,
   output sdrc_cmd_pkg::sdrc_cmd_e    cmd,
   output logic [`SDRC_ROW_W-1:0]     addr,
   output logic [`SDRC_LEN_W-1:0]     out_len,
   output logic [`SDRC_ID_W-1:0]      out_id
);

   sdrc_bank_pkg::bank_state_e state;
   logic                       row_open;   // Some row is active in this bank
   sdrc_bank_pkg::row_t        open_row;

   // Latched request
   sdrc_bank_pkg::row_t        req_row;
   sdrc_bank_pkg::col_t        req_col;
   logic [`SDRC_LEN_W-1:0]     req_len;
   logic [`SDRC_ID_W-1:0]      req_id;
   logic                       req_write;

   // Down-counters, zero means the delay has expired
   logic [`SDRC_TMR_W-1:0]     tras_cnt;
   logic [`SDRC_TMR_W-1:0]     trp_cnt;
   logic [`SDRC_TMR_W-1:0]     trcd_cnt;

   logic                       page_hit;

   assign ack      = req & (state == sdrc_bank_pkg::BS_IDLE);  // Same cycle as the take
   assign page_hit = row_open & (raddr == open_row);
   assign out_len  = req_len;
   assign out_id   = req_id;

   // Command towards the transfer controller
   always_comb begin
      bank_req = 1'b0;
      cmd      = sdrc_cmd_pkg::CMD_PRECHARGE;
      addr     = req_row;                 // Don't-care for precharge
      case (state)
         sdrc_bank_pkg::BS_PRE: begin
            bank_req = (tras_cnt == '0);  // Row must stay open for tRAS
         end
         sdrc_bank_pkg::BS_ACT: begin
            bank_req = 1'b1;
            cmd      = sdrc_cmd_pkg::CMD_ACTIVATE;
         end
         sdrc_bank_pkg::BS_XFR: begin
            bank_req = xfr_ok;            // Oldest request only
            cmd      = req_write ? sdrc_cmd_pkg::CMD_WRITE : sdrc_cmd_pkg::CMD_READ;
            addr     = req_col;
         end
         default: begin
         end
      endcase
   end

   // State, row status and timers
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= sdrc_bank_pkg::BS_IDLE;
         row_open <= 1'b0;                // All rows closed after reset
         tras_cnt <= '0;
         trp_cnt  <= '0;
         trcd_cnt <= '0;
      end else begin
         // Free-running countdown, saturates at zero
         if (tras_cnt != '0) tras_cnt <= tras_cnt - 1'b1;
         if (trp_cnt != '0)  trp_cnt  <= trp_cnt - 1'b1;
         if (trcd_cnt != '0) trcd_cnt <= trcd_cnt - 1'b1;

         case (state)
            sdrc_bank_pkg::BS_IDLE: begin
               if (req) begin
                  if (page_hit)      state <= sdrc_bank_pkg::BS_XFR;
                  else if (row_open) state <= sdrc_bank_pkg::BS_PRE;  // Miss
                  else               state <= sdrc_bank_pkg::BS_ACT;
               end
            end
            sdrc_bank_pkg::BS_PRE: begin
               if (x2b_ack) begin
                  state    <= sdrc_bank_pkg::BS_TRP;
                  row_open <= 1'b0;
                  trp_cnt  <= trp_delay - 1'b1;
               end
            end
            sdrc_bank_pkg::BS_TRP: begin
               if (trp_cnt == '0) state <= sdrc_bank_pkg::BS_ACT;
            end
            sdrc_bank_pkg::BS_ACT: begin
               if (x2b_ack) begin
                  state    <= sdrc_bank_pkg::BS_TRCD;
                  row_open <= 1'b1;
                  tras_cnt <= tras_delay - 1'b1;  // Both start at the activate ack
                  trcd_cnt <= trcd_delay - 1'b1;
               end
            end
            sdrc_bank_pkg::BS_TRCD: begin
               if (trcd_cnt == '0) state <= sdrc_bank_pkg::BS_XFR;
            end
            sdrc_bank_pkg::BS_XFR: begin
               if (x2b_ack) state <= sdrc_bank_pkg::BS_IDLE;  // Row left open
            end
            default: state <= sdrc_bank_pkg::BS_IDLE;
         endcase
      end
   end

   // Payload, valid only while the FSM is busy
   always_ff @(posedge clk) begin
      if (ack) begin
         req_row   <= raddr;
         req_col   <= caddr;
         req_len   <= len;
         req_id    <= id;
         req_write <= write;
      end
      if ((state == sdrc_bank_pkg::BS_ACT) && x2b_ack)
         open_row <= req_row;
   end

endmodule

//--- hw/sdrc_rank_queue.sv
// Rank queue of the bank controller
// Keeps bank addresses in arrival order and grants the oldest requesting bank
`timescale 1ns/1ns
`include "sdrc_params.svh"

module sdrc_rank_queue (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic [1:0]                req_depth,  // Extra limit on entries
   input  logic                      push,
   input  sdrc_bank_pkg::bank_t      push_ba,
   input  logic                      pop,        // Head finished its read/write
   input  logic [`SDRC_BANKS-1:0]    bank_req,
   output sdrc_bank_pkg::bank_t      head_ba,
   output logic                      grant_valid,
   output sdrc_bank_pkg::bank_t      grant_ba,
   output logic                      empty,
   output logic                      full
);

   localparam int IDX_W = $clog2(`SDRC_RANK_DEPTH);

   sdrc_bank_pkg::bank_t      q [`SDRC_RANK_DEPTH];  // Entry 0 is the oldest
   logic [`SDRC_CNT_W-1:0]    cnt;
   logic [`SDRC_CNT_W-1:0]    wr_pos;

   assign head_ba = q[0];
   assign empty   = (cnt == '0);
   // Depth 0 accepts nothing
   assign full    = (cnt == `SDRC_CNT_W'(`SDRC_RANK_DEPTH)) | (cnt == {1'b0, req_depth});
   assign wr_pos  = pop ? cnt - 1'b1 : cnt;  // Slot after the shift

   // Oldest queued bank with a pending command wins
   always_comb begin
      grant_valid = 1'b0;
      grant_ba    = q[0];
      for (int i = `SDRC_RANK_DEPTH - 1; i >= 0; i--) begin
         if ((i < cnt) && bank_req[q[i]]) begin
            grant_valid = 1'b1;
            grant_ba    = q[i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         cnt <= '0;
      end else begin
         case ({push, pop})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;      // Both or neither
         endcase
      end
   end

   // Shift toward the head on pop, then fill the first free slot
   always_ff @(posedge clk) begin
      if (pop) begin
         for (int i = 0; i < `SDRC_RANK_DEPTH - 1; i++)
            q[i] <= q[i+1];
      end
      if (push)
         q[wr_pos[IDX_W-1:0]] <= push_ba;
   end

endmodule

//--- hw/sdrc_bank_ctl.sv
// SDRAM bank controller top level
// Routes requests to four bank FSMs and muxes their commands to the transfer side
`timescale 1ns/1ns
`include "sdrc_params.svh"

module sdrc_bank_ctl (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic [1:0]                a2b_req_depth,
   input  logic                      r2b_req,
   input  sdrc_bank_pkg::bank_t      r2b_ba,
   input  sdrc_bank_pkg::row_t       r2b_raddr,
   input  sdrc_bank_pkg::col_t       r2b_caddr,
   input  logic [`SDRC_LEN_W-1:0]    r2b_len,
   input  logic [`SDRC_ID_W-1:0]     r2b_id,
   input  logic                      r2b_write,
   input  logic                      x2b_ack,
   input  logic [`SDRC_TMR_W-1:0]    tras_delay,
   input  logic [`SDRC_TMR_W-1:0]    trp_delay,
   input  logic [`SDRC_TMR_W-1:0]    trcd_delay,
   output logic                      b2r_ack,
   output logic                      b2r_arb_ok,
   output logic                      b2x_req,
   output sdrc_bank_pkg::bank_t      b2x_ba,
   output sdrc_cmd_pkg::sdrc_cmd_e   b2x_cmd,
   output logic [`SDRC_ROW_W-1:0]    b2x_addr,
   output logic [`SDRC_LEN_W-1:0]    b2x_len,
   output logic [`SDRC_ID_W-1:0]     b2x_id,
   output logic                      b2x_idle
);

   logic [`SDRC_BANKS-1:0]    bank_sel_req;  // Request demux
   logic [`SDRC_BANKS-1:0]    bank_ack;
   logic [`SDRC_BANKS-1:0]    bank_req;
   logic [`SDRC_BANKS-1:0]    bank_xfr_ok;
   logic [`SDRC_BANKS-1:0]    bank_x_ack;
   sdrc_cmd_pkg::sdrc_cmd_e   bank_cmd  [`SDRC_BANKS];
   logic [`SDRC_ROW_W-1:0]    bank_addr [`SDRC_BANKS];
   logic [`SDRC_LEN_W-1:0]    bank_len  [`SDRC_BANKS];
   logic [`SDRC_ID_W-1:0]     bank_id   [`SDRC_BANKS];

   sdrc_bank_pkg::bank_t      head_ba, grant_ba, sel_ba, hold_ba;
   logic                      grant_valid, q_empty, q_full, q_pop;
   logic                      hold_valid;    // Command waiting for x2b_ack

   assign b2r_ack    = |bank_ack;   // At most one bank acks
   assign b2r_arb_ok = ~q_full;
   assign b2x_idle   = q_empty;

   // Keep the offered command fixed until it is acked
   assign sel_ba   = hold_valid ? hold_ba : grant_ba;
   assign b2x_req  = hold_valid | grant_valid;
   assign b2x_ba   = sel_ba;
   assign b2x_cmd  = bank_cmd[sel_ba];
   assign b2x_addr = bank_addr[sel_ba];
   assign b2x_len  = bank_len[sel_ba];
   assign b2x_id   = bank_id[sel_ba];
   assign q_pop    = b2x_req & b2x_cmd[1] & x2b_ack;  // Read/write done

   always_ff @(posedge clk) begin
      if (!reset_n) hold_valid <= 1'b0;
      else          hold_valid <= b2x_req & ~x2b_ack;
   end

   always_ff @(posedge clk) hold_ba <= sel_ba;

   sdrc_rank_queue u_rank_queue (
      .clk         (clk),
      .reset_n     (reset_n),
      .req_depth   (a2b_req_depth),
      .push        (b2r_ack),
      .push_ba     (r2b_ba),
      .pop         (q_pop),
      .bank_req    (bank_req),
      .head_ba     (head_ba),
      .grant_valid (grant_valid),
      .grant_ba    (grant_ba),
      .empty       (q_empty),
      .full        (q_full)
   );

   for (genvar b = 0; b < `SDRC_BANKS; b++) begin : g_bank
      assign bank_sel_req[b] = r2b_req & ~q_full & (r2b_ba == sdrc_bank_pkg::bank_t'(b));
      assign bank_xfr_ok[b]  = ~q_empty & (head_ba == sdrc_bank_pkg::bank_t'(b));
      assign bank_x_ack[b]   = x2b_ack & b2x_req & (sel_ba == sdrc_bank_pkg::bank_t'(b));

      sdrc_bank_fsm u_bank_fsm (
         .clk        (clk),
         .reset_n    (reset_n),
         .req        (bank_sel_req[b]),
         .raddr      (r2b_raddr),
         .caddr      (r2b_caddr),
         .len        (r2b_len),
         .id         (r2b_id),
         .write      (r2b_write),
         .xfr_ok     (bank_xfr_ok[b]),
         .x2b_ack    (bank_x_ack[b]),
         .tras_delay (tras_delay),
         .trp_delay  (trp_delay),
         .trcd_delay (trcd_delay),
         .ack        (bank_ack[b]),
         .bank_req   (bank_req[b]),
         .cmd        (bank_cmd[b]),
         .addr       (bank_addr[b]),
         .out_len    (bank_len[b]),
         .out_id     (bank_id[b])
      );
   end

endmodule

//--- verif/sdrc_rank_queue_chk.sv
// Rank queue checks, bound into every sdrc_rank_queue
// Push and pop legality, grant only to a queued bank
`timescale 1ns/1ns
`include "sdrc_params.svh"

module sdrc_rank_queue_chk (
   input logic                   clk,
   input logic                   reset_n,
   input logic                   push,
   input logic                   pop,
   input logic                   empty,
   input logic                   full,
   input logic                   grant_valid,
   input sdrc_bank_pkg::bank_t   grant_ba,
   input logic [`SDRC_CNT_W-1:0] cnt,
   input sdrc_bank_pkg::bank_t   q0,   // Oldest
   input sdrc_bank_pkg::bank_t   q1,
   input sdrc_bank_pkg::bank_t   q2,
   input sdrc_bank_pkg::bank_t   q3
);

   logic queued;   // grant_ba sits in a live entry

   assign queued = ((cnt > 3'd0) && (q0 == grant_ba)) ||
                   ((cnt > 3'd1) && (q1 == grant_ba)) ||
                   ((cnt > 3'd2) && (q2 == grant_ba)) ||
                   ((cnt > 3'd3) && (q3 == grant_ba));

   a_pop_empty: assert property (@(posedge clk) disable iff (!reset_n) pop |-> !empty)
      else $error("rank queue popped while empty");
   a_push_full: assert property (@(posedge clk) disable iff (!reset_n) push && full |-> pop)
      else $error("rank queue pushed while full");
   a_grant: assert property (@(posedge clk) disable iff (!reset_n) grant_valid |-> queued)
      else $error("grant to a bank that is not queued");

endmodule

bind sdrc_rank_queue sdrc_rank_queue_chk u_chk (
   .clk         (clk),
   .reset_n     (reset_n),
   .push        (push),
   .pop         (pop),
   .empty       (empty),
   .full        (full),
   .grant_valid (grant_valid),
   .grant_ba    (grant_ba),
   .cnt         (cnt),
   .q0          (q[0]),
   .q1          (q[1]),
   .q2          (q[2]),
   .q3          (q[3])
);

//--- verif/tb_sdrc_bank_ctl.sv
// Testbench for the SDRAM bank controller
// Directed tests against a reference model of the open row in each bank
`timescale 1ns/1ns
`include "sdrc_params.svh"

module tb_sdrc_bank_ctl;

   localparam int TRAS = 5;
   localparam int TRP  = 2;
   localparam int TRCD = 3;
   localparam logic [`SDRC_LEN_W-1:0] LEN = 7'd8;
   localparam int BUDGET = 10 + 6 * 60 + 100;   // Reset, 6 tests of up to 60 cycles, margin

   logic clk, reset_n, r2b_req, r2b_write, x2b_ack;
   logic [1:0] a2b_req_depth;
   sdrc_bank_pkg::bank_t r2b_ba, b2x_ba;
   sdrc_bank_pkg::row_t r2b_raddr;
   sdrc_bank_pkg::col_t r2b_caddr;
   logic [`SDRC_LEN_W-1:0] r2b_len, b2x_len;
   logic [`SDRC_ID_W-1:0] r2b_id, b2x_id;
   logic [`SDRC_TMR_W-1:0] tras_delay, trp_delay, trcd_delay;
   logic b2r_ack, b2r_arb_ok, b2x_req, b2x_idle;
   sdrc_cmd_pkg::sdrc_cmd_e b2x_cmd;
   logic [`SDRC_ROW_W-1:0] b2x_addr;

   sdrc_bank_pkg::row_t open_row [`SDRC_BANKS];   // Reference row model
   logic row_valid [`SDRC_BANKS];
   int act_cyc [`SDRC_BANKS];                     // Cycle of the last activate ack
   logic [15:0] lfsr = 16'd50;
   int cyc = 0;
   int errors = 0;
   int err_mark, tests, failed;
   sdrc_bank_pkg::bank_t got_ba [$];              // Read/write order, ordering test
   logic [`SDRC_ID_W-1:0] got_id [$];

   sdrc_bank_ctl uut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // Fibonacci LFSR x^16+x^14+x^13+x^11, one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      logic fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH time=%0t %s expected=0x%0h actual=0x%0h", $time, name, exp, got);
         errors++;
      end
   endtask

   task automatic check_gap(string what, int gap, int min_gap);
      assert (gap >= min_gap) else begin
         $display("ERROR time=%0t %s after %0d cycles, minimum is %0d",
                  $time, what, gap, min_gap);
         errors++;
      end
   endtask

   task automatic end_test(string name);
      tests++;
      if (errors != err_mark) failed++;
      $display("test %s: %s", name, (errors == err_mark) ? "ok" : "FAILED");
   endtask

   task automatic send_req(sdrc_bank_pkg::bank_t ba, sdrc_bank_pkg::row_t row,
                           sdrc_bank_pkg::col_t col, logic wr, logic [`SDRC_ID_W-1:0] id);
      @(posedge clk);
      r2b_req   <= 1'b1;
      r2b_ba    <= ba;
      r2b_raddr <= row;
      r2b_caddr <= col;
      r2b_write <= wr;
      r2b_id    <= id;
      r2b_len   <= LEN;
      @(negedge clk);
      while (!b2r_ack) @(negedge clk);   // Taken at the next edge
      @(posedge clk) r2b_req <= 1'b0;
   endtask

   task automatic wait_cmd();
      @(negedge clk);
      while (!b2x_req) @(negedge clk);
   endtask

   // One-cycle x2b_ack, returns the cycle it was taken in
   task automatic ack_cmd(output int t);
      @(posedge clk) x2b_ack <= 1'b1;
      @(posedge clk) x2b_ack <= 1'b0;
      @(negedge clk) t = cyc;
   endtask

   // Returns the cycle the command first showed up and the cycle it was acked
   task automatic serve(sdrc_cmd_pkg::sdrc_cmd_e cmd, sdrc_bank_pkg::bank_t ba,
                        logic [`SDRC_ROW_W-1:0] addr, logic [`SDRC_LEN_W-1:0] len,
                        logic [`SDRC_ID_W-1:0] id, int hold,
                        output int t_req, output int t_ack);
      logic [31:0] snap;
      wait_cmd();
      t_req = cyc;
      check_val("b2x_cmd", b2x_cmd, cmd);
      check_val("b2x_ba", b2x_ba, ba);
      if (cmd != sdrc_cmd_pkg::CMD_PRECHARGE) check_val("b2x_addr", b2x_addr, addr);
      if (cmd[1]) begin                   // Read or write
         check_val("b2x_len", b2x_len, len);
         check_val("b2x_id", b2x_id, id);
      end
      snap = {b2x_cmd, b2x_ba, b2x_addr, b2x_len, b2x_id};
      repeat (hold) begin                 // Ack withheld, command must not move
         @(negedge clk);
         check_val("b2x_req", b2x_req, 1);
         check_val("b2x fields", {b2x_cmd, b2x_ba, b2x_addr, b2x_len, b2x_id}, snap);
      end
      ack_cmd(t_ack);
   endtask

   task automatic test_reset();
      err_mark = errors;
      @(negedge clk);
      check_val("b2x_idle", b2x_idle, 1);
      check_val("b2x_req", b2x_req, 0);
      check_val("b2r_arb_ok", b2r_arb_ok, 1);
      end_test("reset");
   endtask

   // Single request, command sequence predicted from the row model
   task automatic access_test(string name, sdrc_bank_pkg::bank_t ba,
                              sdrc_bank_pkg::row_t row, logic wr, int hold);
      sdrc_bank_pkg::col_t col;
      logic [`SDRC_ID_W-1:0] id;
      logic miss;
      logic opened;
      int t_pre, t_act, t_xfr;
      int r_pre, r_act, r_xfr;
      err_mark = errors;
      col    = sdrc_bank_pkg::col_t'(rand_bits(`SDRC_COL_W));
      id     = `SDRC_ID_W'(rand_bits(`SDRC_ID_W));
      miss   = row_valid[ba] && (open_row[ba] != row);
      opened = !row_valid[ba] || miss;
      send_req(ba, row, col, wr, id);
      if (miss) begin
         serve(sdrc_cmd_pkg::CMD_PRECHARGE, ba, '0, '0, '0, hold, r_pre, t_pre);
         check_gap("precharge after activate", r_pre - act_cyc[ba], TRAS);
      end
      if (opened) begin
         serve(sdrc_cmd_pkg::CMD_ACTIVATE, ba, row, '0, '0, hold, r_act, t_act);
         if (miss) check_gap("activate after precharge", r_act - t_pre, TRP);
         act_cyc[ba]   = t_act;
         open_row[ba]  = row;
         row_valid[ba] = 1'b1;
      end
      serve(wr ? sdrc_cmd_pkg::CMD_WRITE : sdrc_cmd_pkg::CMD_READ,
            ba, `SDRC_ROW_W'(col), LEN, id, hold, r_xfr, t_xfr);
      if (opened) check_gap("read/write after activate", r_xfr - act_cyc[ba], TRCD);
      end_test(name);
   endtask

   // Depth 2, third request must wait for the first read to leave
   task automatic test_order();
      sdrc_bank_pkg::bank_t bas [3];
      logic [`SDRC_ID_W-1:0] ids [3];
      int t;
      err_mark = errors;
      bas = '{2'd2, 2'd1, 2'd3};
      for (int i = 0; i < 3; i++) ids[i] = `SDRC_ID_W'(rand_bits(`SDRC_ID_W));
      got_ba.delete();
      got_id.delete();
      @(posedge clk) a2b_req_depth <= 2'd2;
      fork
         for (int i = 0; i < 3; i++) begin
            if (i == 2) begin
               @(negedge clk);
               check_val("b2r_arb_ok", b2r_arb_ok, 0);   // Two queued, limit reached
            end
            send_req(bas[i], 13'h0a00, sdrc_bank_pkg::col_t'(rand_bits(`SDRC_COL_W)),
                     1'b0, ids[i]);
         end
         while (got_ba.size() < 3) begin
            wait_cmd();
            if (b2x_cmd[1]) begin
               got_ba.push_back(b2x_ba);
               got_id.push_back(b2x_id);
            end else if (b2x_cmd == sdrc_cmd_pkg::CMD_ACTIVATE) begin
               open_row[b2x_ba]  = b2x_addr;
               row_valid[b2x_ba] = 1'b1;
            end
            ack_cmd(t);
         end
      join
      for (int i = 0; i < 3; i++) begin
         check_val("read order b2x_ba", got_ba[i], bas[i]);
         check_val("read order b2x_id", got_id[i], ids[i]);
      end
      @(posedge clk) a2b_req_depth <= 2'd3;
      end_test("order_depth");
   endtask

   initial begin
      reset_n       = 1'b0;
      a2b_req_depth = 2'd3;
      r2b_req       = 1'b0;
      r2b_ba        = '0;
      r2b_raddr     = '0;
      r2b_caddr     = '0;
      r2b_len       = '0;
      r2b_id        = '0;
      r2b_write     = 1'b0;
      x2b_ack       = 1'b0;
      tras_delay    = `SDRC_TMR_W'(TRAS);
      trp_delay     = `SDRC_TMR_W'(TRP);
      trcd_delay    = `SDRC_TMR_W'(TRCD);
      tests         = 0;
      failed        = 0;
      for (int b = 0; b < `SDRC_BANKS; b++) begin
         row_valid[b] = 1'b0;             // All rows closed after reset
         act_cyc[b]   = 0;
      end
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;
      test_reset();
      access_test("closed_row_read", 2'd0, 13'h0123, 1'b0, 0);
      access_test("page_hit_write", 2'd0, 13'h0123, 1'b1, 0);
      access_test("page_miss_read", 2'd0, 13'h0456, 1'b0, 0);
      test_order();
      access_test("back_pressure", 2'd0, 13'h0789, 1'b1, 3);   // Miss, every ack 3 late
      $display("Done: %0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0) $display("All tests passed!");
      else $display("Test failures found");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (BUDGET) @(posedge clk);
      $display("Timeout after %0d cycles, a handshake never completed", BUDGET);
      $display("Test failures found");
      $finish;
   end

endmodule

//--- project.f
+incdir+hw
hw/sdrc_cmd_pkg.sv
hw/sdrc_bank_pkg.sv
hw/sdrc_bank_fsm.sv
hw/sdrc_rank_queue.sv
hw/sdrc_bank_ctl.sv
verif/sdrc_rank_queue_chk.sv
verif/tb_sdrc_bank_ctl.sv

//--- Makefile
VERILATOR = verilator
TOP       = tb_sdrc_bank_ctl
FILELIST  = project.f
VFLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard hw/*.sv hw/*.svh verif/*.sv)
PASS_MSG  = All tests passed!

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
